// File: Makefile
VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/issue_buffer.sv
`timescale 1ns/1ps

module issue_buffer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  issue_pkg::inst_t [1:0]      dec,
    input  logic [issue_pkg::ptr_w-1:0] head,
    input  logic [issue_pkg::ptr_w-1:0] tail,
    input  logic [issue_pkg::cnt_w-1:0] count,
    input  logic [1:0]                  push_cnt,
    input  logic [1:0]                  skip_cnt,
    output issue_pkg::inst_t [1:0]      cand
);
    import issue_pkg::*;

    inst_t              mem [queue_depth];
    inst_t              first_src;
    logic [ptr_w-1:0]   head_nx;
    logic [ptr_w-1:0]   tail_nx;

    // pointers wrap at the queue depth
    assign head_nx = head + ptr_w'(1);
    assign tail_nx = tail + ptr_w'(1);

    // the oldest unissued decode lane goes in first
    always_comb begin
        if (skip_cnt == 2'd0) begin
            first_src = dec[0];
        end else begin
            first_src = dec[1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < queue_depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (push_cnt != 2'd0) begin
                mem[tail] <= first_src;
            end
            // two pushes only happen when nothing skipped
            if (push_cnt == 2'd2) begin
                mem[tail_nx] <= dec[1];
            end
        end
    end

    // two oldest instructions with the queue ahead of decode
    always_comb begin
        if (count >= cnt_w'(2)) begin
            cand[0] = mem[head];
            cand[1] = mem[head_nx];
        end else if (count == cnt_w'(1)) begin
            cand[0] = mem[head];
            cand[1] = dec[0];
        end else begin
            cand[0] = dec[0];
            cand[1] = dec[1];
        end
    end

endmodule

// File: hdl/issue_pkg.sv
package issue_pkg;

    // queue geometry
    localparam int queue_depth = 16;
    localparam int ptr_w       = 4;
    localparam int cnt_w       = 5;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_t;

    typedef enum logic [3:0] {
        alu,
        mult,
        multu,
        div,
        divu,
        mfhi,
        mflo,
        mthi,
        mtlo,
        mfc0,
        mtc0,
        branch,
        jump,
        load,
        store,
        other
    } op_e;

    typedef enum logic [1:0] {
        none,
        exception,
        eret
    } cp0_kind_e;

    // one decoded instruction as it leaves decode
    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       raw_instr;
        op_e         op;
        logic [15:0] imm;
        reg_t        ra1;
        reg_t        ra2;
        reg_t        rdst;
        reg_t        cp0ra;
        logic        regwrite;
        logic        hiwrite;
        logic        lowrite;
        logic        cp0write;
        logic        hi_read;
        logic        lo_read;
        logic        cp0_read;
        cp0_kind_e   cp0_kind;
    } inst_t;

    // record handed to execute
    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       raw_instr;
        op_e         op;
        logic [15:0] imm;
        reg_t        rdst;
        reg_t        cp0ra;
        cp0_kind_e   cp0_kind;
        logic        is_slot;
        word_t       rd1;
        word_t       rd2;
    } issued_t;

    // per-operand status from the forwarding unit
    typedef struct packed {
        logic  ready;
        logic  bypass;
        word_t data;
    } opnd_stat_t;

    // read addresses sent to the forwarding unit
    typedef struct packed {
        reg_t ra1;
        reg_t ra2;
        reg_t cp0ra;
        logic hi_read;
        logic lo_read;
        logic cp0_read;
    } rd_req_t;

endpackage

// File: hdl/issue_ptrs.sv
`timescale 1ns/1ps

module issue_ptrs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic [1:0]                  in_cnt,
    input  logic [1:0]                  issue_cnt,
    output logic [issue_pkg::ptr_w-1:0] head,
    output logic [issue_pkg::ptr_w-1:0] tail,
    output logic [issue_pkg::cnt_w-1:0] count,
    output logic [1:0]                  push_cnt,
    output logic [1:0]                  skip_cnt,
    output logic                        full
);
    import issue_pkg::*;

    logic [1:0] pop_cnt;

    // queued entries are older, so they leave first
    always_comb begin
        if (cnt_w'(issue_cnt) < count) begin
            pop_cnt = issue_cnt;
        end else begin
            pop_cnt = count[1:0];
        end
    end

    // whatever issues beyond the queue came straight from decode
    assign skip_cnt = issue_cnt - pop_cnt;

    // fewer than two free slots
    assign full = count > cnt_w'(queue_depth - 2);

    always_comb begin
        if (full || flush) begin
            push_cnt = 2'd0;
        end else begin
            push_cnt = in_cnt - skip_cnt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_w'(pop_cnt);
            tail  <= tail + ptr_w'(push_cnt);
            count <= count + cnt_w'(push_cnt) - cnt_w'(pop_cnt);
        end
    end

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  issue_pkg::inst_t [1:0]      dec,
    input  issue_pkg::word_t [1:0]      rf_rd1,
    input  issue_pkg::word_t [1:0]      rf_rd2,
    input  issue_pkg::opnd_stat_t [1:0] opnd1,
    input  issue_pkg::opnd_stat_t [1:0] opnd2,
    input  logic                        flush,
    input  logic                        stall_issue,
    output issue_pkg::issued_t [1:0]    iss,
    output issue_pkg::rd_req_t [1:0]    rd_req,
    output logic                        full
);
    import issue_pkg::*;

    inst_t [1:0]        cand;
    logic [ptr_w-1:0]   head;
    logic [ptr_w-1:0]   tail;
    logic [cnt_w-1:0]   count;
    logic [1:0]         push_cnt;
    logic [1:0]         skip_cnt;
    logic [1:0]         in_cnt;
    logic [1:0]         issue_en;
    logic [1:0]         issue_cnt;
    logic               slot;

    // decode lanes are contiguous
    assign in_cnt = {1'b0, dec[0].valid} + {1'b0, dec[1].valid};

    issue_ptrs ptrs_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_cnt    (in_cnt),
        .issue_cnt (issue_cnt),
        .head      (head),
        .tail      (tail),
        .count     (count),
        .push_cnt  (push_cnt),
        .skip_cnt  (skip_cnt),
        .full      (full)
    );

    issue_buffer buffer_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .dec      (dec),
        .head     (head),
        .tail     (tail),
        .count    (count),
        .push_cnt (push_cnt),
        .skip_cnt (skip_cnt),
        .cand     (cand)
    );

    pair_check check_i (
        .cand        (cand),
        .opnd1       (opnd1),
        .opnd2       (opnd2),
        .stall_issue (stall_issue),
        .flush       (flush),
        .issue_en    (issue_en),
        .slot        (slot),
        .issue_cnt   (issue_cnt)
    );

    operand_sel sel_i (
        .cand     (cand),
        .issue_en (issue_en),
        .slot     (slot),
        .rf_rd1   (rf_rd1),
        .rf_rd2   (rf_rd2),
        .opnd1    (opnd1),
        .opnd2    (opnd2),
        .iss      (iss),
        .rd_req   (rd_req)
    );

endmodule

// File: hdl/operand_sel.sv
`timescale 1ns/1ps

module operand_sel (
    input  issue_pkg::inst_t [1:0]      cand,
    input  logic [1:0]                  issue_en,
    input  logic                        slot,
    input  issue_pkg::word_t [1:0]      rf_rd1,
    input  issue_pkg::word_t [1:0]      rf_rd2,
    input  issue_pkg::opnd_stat_t [1:0] opnd1,
    input  issue_pkg::opnd_stat_t [1:0] opnd2,
    output issue_pkg::issued_t [1:0]    iss,
    output issue_pkg::rd_req_t [1:0]    rd_req
);
    import issue_pkg::*;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            iss[i] = '0;
            if (issue_en[i]) begin
                iss[i].valid     = 1'b1;
                iss[i].pc        = cand[i].pc;
                iss[i].raw_instr = cand[i].raw_instr;
                iss[i].op        = cand[i].op;
                iss[i].imm       = cand[i].imm;
                iss[i].rdst      = cand[i].rdst;
                iss[i].cp0ra     = cand[i].cp0ra;
                iss[i].cp0_kind  = cand[i].cp0_kind;
                // only the younger lane can be a delay slot
                iss[i].is_slot   = (i == 1) && slot;
                iss[i].rd1       = opnd1[i].bypass ? opnd1[i].data : rf_rd1[i];
                iss[i].rd2       = opnd2[i].bypass ? opnd2[i].data : rf_rd2[i];
            end
        end
    end

    // forwarding lookups follow the candidates, issued or not
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_req[i].ra1      = cand[i].ra1;
            rd_req[i].ra2      = cand[i].ra2;
            rd_req[i].cp0ra    = cand[i].cp0ra;
            rd_req[i].hi_read  = cand[i].hi_read;
            rd_req[i].lo_read  = cand[i].lo_read;
            rd_req[i].cp0_read = cand[i].cp0_read;
        end
    end

endmodule

// File: hdl/pair_check.sv
`timescale 1ns/1ps

module pair_check (
    input  issue_pkg::inst_t [1:0]      cand,
    input  issue_pkg::opnd_stat_t [1:0] opnd1,
    input  issue_pkg::opnd_stat_t [1:0] opnd2,
    input  logic                        stall_issue,
    input  logic                        flush,
    output logic [1:0]                  issue_en,
    output logic                        slot,
    output logic [1:0]                  issue_cnt
);
    import issue_pkg::*;

    logic ready0;
    logic ready1;
    logic br0;
    logic raw_hz;
    logic conflict;
    logic pair_ok;
    logic go;

    function automatic logic is_muldiv(op_e op);
        return op == mult || op == multu || op == div || op == divu;
    endfunction

    function automatic logic is_branch(op_e op);
        return op == branch || op == jump;
    endfunction

    assign ready0 = cand[0].valid && opnd1[0].ready && opnd2[0].ready;
    assign ready1 = cand[1].valid && opnd1[1].ready && opnd2[1].ready;
    assign br0    = is_branch(cand[0].op);

    // a branch writing its link register does not block its own slot
    assign raw_hz = cand[0].regwrite && !br0
                 && (cand[0].rdst == cand[1].ra1 || cand[0].rdst == cand[1].ra2);

    always_comb begin
        conflict = raw_hz;
        conflict = conflict || (is_muldiv(cand[0].op) && is_muldiv(cand[1].op));
        conflict = conflict || (cand[0].cp0write && cand[1].cp0write);
        conflict = conflict || (cand[0].cp0write && cand[1].cp0_read);
        conflict = conflict || (cand[0].hiwrite && cand[1].hi_read);
        conflict = conflict || (cand[0].lowrite && cand[1].lo_read);
        // only one exception or eret per cycle
        conflict = conflict || (cand[0].cp0_kind != none && cand[1].cp0_kind != none);
        conflict = conflict || is_branch(cand[1].op);
    end

    assign go      = !stall_issue && !flush;
    assign pair_ok = ready0 && ready1 && !conflict;

    // branch or jump goes only together with its delay slot
    assign issue_en[0] = go && ready0 && (!br0 || pair_ok);
    assign issue_en[1] = go && pair_ok;

    assign slot      = br0 && issue_en[1];
    assign issue_cnt = {1'b0, issue_en[0]} + {1'b0, issue_en[1]};

endmodule

// File: sim/issue_stage_assert.sv
`timescale 1ns/1ps

module issue_stage_assert (
    input  logic                        clk,
    input  logic                        arst_n,
    input  issue_pkg::inst_t [1:0]      dec,
    input  issue_pkg::inst_t [1:0]      cand,
    input  issue_pkg::word_t [1:0]      rf_rd1,
    input  issue_pkg::word_t [1:0]      rf_rd2,
    input  issue_pkg::opnd_stat_t [1:0] opnd1,
    input  issue_pkg::opnd_stat_t [1:0] opnd2,
    input  logic                        flush,
    input  logic                        stall_issue,
    input  issue_pkg::issued_t [1:0]    iss,
    input  issue_pkg::rd_req_t [1:0]    rd_req,
    input  logic [issue_pkg::cnt_w-1:0] count,
    input  logic                        full
);
    import issue_pkg::*;

    int    fail_cnt = 0;
    logic  exp_vld;
    word_t exp_pc;
    word_t exp_now;

    function automatic logic is_br(op_e op);
        return op == branch || op == jump;
    endfunction

    function automatic logic is_md(op_e op);
        return op inside {mult, multu, div, divu};
    endfunction

    // any of the pairing hazards between an older and a younger instruction
    function automatic logic hazard(inst_t a, inst_t b);
        logic reads_dst;
        reads_dst = b.ra1 == a.rdst || b.ra2 == a.rdst;
        return (a.regwrite && reads_dst && !is_br(a.op))
            || (is_md(a.op) && is_md(b.op))
            || (a.cp0write && (b.cp0write || b.cp0_read))
            || (a.hiwrite && b.hi_read)
            || (a.lowrite && b.lo_read)
            || (a.cp0_kind != none && b.cp0_kind != none)
            || is_br(b.op);
    endfunction

    // expected next pc which restarts from decode after a flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_vld <= 1'b0;
            exp_pc  <= '0;
        end else if (flush) begin
            exp_vld <= 1'b0;
        end else if (iss[0].valid) begin
            exp_vld <= 1'b1;
            exp_pc  <= exp_now + (iss[1].valid ? 32'd8 : 32'd4);
        end else if (!exp_vld && dec[0].valid && !full) begin
            exp_vld <= 1'b1;
            exp_pc  <= dec[0].pc;
        end
    end

    assign exp_now = exp_vld ? exp_pc : dec[0].pc;

    a_order0: assert property (@(posedge clk) disable iff (!arst_n)
        iss[0].valid |-> iss[0].pc == exp_now)
        else begin
            fail_cnt++;
            $error("MISMATCH t=%0t iss[0].pc got %h expected %h",
                   $time, $sampled(iss[0].pc), $sampled(exp_now));
        end

    a_order1: assert property (@(posedge clk) disable iff (!arst_n)
        iss[1].valid |-> iss[0].valid && iss[1].pc == exp_now + 32'd4)
        else begin
            fail_cnt++;
            $error("MISMATCH t=%0t iss[1].pc got %h expected %h",
                   $time, $sampled(iss[1].pc), $sampled(exp_now) + 32'd4);
        end

    a_pair: assert property (@(posedge clk) disable iff (!arst_n)
        iss[0].valid && iss[1].valid |-> !hazard(cand[0], cand[1]))
        else begin
            fail_cnt++;
            $error("two conflicting instructions issued in the same cycle");
        end

    a_slot: assert property (@(posedge clk) disable iff (!arst_n)
        iss[0].valid && is_br(iss[0].op) |-> iss[1].valid && iss[1].is_slot)
        else begin
            fail_cnt++;
            $error("branch or jump issued without its delay slot");
        end

    a_lane1: assert property (@(posedge clk) disable iff (!arst_n)
        iss[1].valid |-> !is_br(iss[1].op) && iss[1].is_slot == is_br(iss[0].op)
                         && !iss[0].is_slot)
        else begin
            fail_cnt++;
            $error("younger lane is a branch or carries a wrong slot mark");
        end

    for (genvar i = 0; i < 2; i++) begin : g_lane
        word_t exp_rd1;
        word_t exp_rd2;

        assign exp_rd1 = opnd1[i].bypass ? opnd1[i].data : rf_rd1[i];
        assign exp_rd2 = opnd2[i].bypass ? opnd2[i].data : rf_rd2[i];

        a_ready: assert property (@(posedge clk) disable iff (!arst_n)
            iss[i].valid |-> iss[i].pc == cand[i].pc && opnd1[i].ready && opnd2[i].ready)
            else begin
                fail_cnt++;
                $error("lane %0d issued a candidate whose operands were not ready", i);
            end

        a_rd1: assert property (@(posedge clk) disable iff (!arst_n)
            iss[i].valid |-> iss[i].rd1 == exp_rd1)
            else begin
                fail_cnt++;
                $error("MISMATCH t=%0t iss[%0d].rd1 got %h expected %h",
                       $time, i, $sampled(iss[i].rd1), $sampled(exp_rd1));
            end

        a_rd2: assert property (@(posedge clk) disable iff (!arst_n)
            iss[i].valid |-> iss[i].rd2 == exp_rd2)
            else begin
                fail_cnt++;
                $error("MISMATCH t=%0t iss[%0d].rd2 got %h expected %h",
                       $time, i, $sampled(iss[i].rd2), $sampled(exp_rd2));
            end

        // stimulus carries each read request in the low bits of raw_instr
        a_req: assert property (@(posedge clk) disable iff (!arst_n)
            rd_req[i] == cand[i].raw_instr[17:0])
            else begin
                fail_cnt++;
                $error("MISMATCH t=%0t rd_req[%0d] got %h expected %h",
                       $time, i, $sampled(rd_req[i]), $sampled(cand[i].raw_instr[17:0]));
            end
    end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall_issue || flush |-> !iss[0].valid && !iss[1].valid)
        else begin
            fail_cnt++;
            $error("instruction issued during stall or flush");
        end

    a_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> count == '0)
        else begin
            fail_cnt++;
            $error("queue not empty after flush");
        end

    // full means fewer than two free entries
    a_full: assert property (@(posedge clk) disable iff (!arst_n)
        full == (cnt_w'(queue_depth) - count < cnt_w'(2)) && count <= cnt_w'(queue_depth))
        else begin
            fail_cnt++;
            $error("full flag does not match queue occupancy");
        end

    a_reset: assert property (@(posedge clk)
        !arst_n |-> !full && !iss[0].valid)
        else begin
            fail_cnt++;
            $error("full or issue valid high during reset");
        end

endmodule

bind issue_stage issue_stage_assert chk_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .dec         (dec),
    .cand        (cand),
    .rf_rd1      (rf_rd1),
    .rf_rd2      (rf_rd2),
    .opnd1       (opnd1),
    .opnd2       (opnd2),
    .flush       (flush),
    .stall_issue (stall_issue),
    .iss         (iss),
    .rd_req      (rd_req),
    .count       (count),
    .full        (full)
);

// File: sim/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;
    import issue_pkg::*;

    logic             clk;
    logic             arst_n;
    inst_t [1:0]      dec;
    word_t [1:0]      rf_rd1;
    word_t [1:0]      rf_rd2;
    opnd_stat_t [1:0] opnd1;
    opnd_stat_t [1:0] opnd2;
    logic             flush;
    logic             stall_issue;
    issued_t [1:0]    iss;
    rd_req_t [1:0]    rd_req;
    logic             full;

    logic [31:0]      rng;
    word_t            next_pc;
    logic             taken;
    int               tests_run;
    int               tests_failed;

    issue_stage dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .dec         (dec),
        .rf_rd1      (rf_rd1),
        .rf_rd2      (rf_rd2),
        .opnd1       (opnd1),
        .opnd2       (opnd2),
        .flush       (flush),
        .stall_issue (stall_issue),
        .iss         (iss),
        .rd_req      (rd_req),
        .full        (full)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic inst_t make_inst(word_t pc, logic allow_br);
        inst_t       t;
        logic [31:0] r;
        logic [31:0] raw_hi;
        r           = next_rand();
        t           = '0;
        t.valid     = 1'b1;
        t.pc        = pc;
        raw_hi      = next_rand();
        t.op        = op_e'(r[3:0]);
        t.imm       = r[31:16];
        // small register range so read-after-write pairs are common
        t.ra1       = {2'b00, r[6:4]};
        t.ra2       = {2'b00, r[9:7]};
        t.rdst      = {2'b00, r[12:10]};
        t.cp0ra     = r[17:13];
        if (!allow_br && (t.op == branch || t.op == jump)) begin
            t.op = alu;
        end
        case (t.op)
            mult, multu, div, divu: begin
                t.hiwrite = 1'b1;
                t.lowrite = 1'b1;
            end
            mthi: t.hiwrite = 1'b1;
            mtlo: t.lowrite = 1'b1;
            mtc0: t.cp0write = 1'b1;
            store: t.regwrite = 1'b0;
            // link write on some branches
            branch, jump: t.regwrite = r[18];
            other: t.cp0_kind = r[19] ? (r[20] ? eret : exception) : none;
            default: t.regwrite = 1'b1;
        endcase
        t.hi_read  = t.op == mfhi;
        t.lo_read  = t.op == mflo;
        t.cp0_read = t.op == mfc0 || t.cp0_kind == eret;
        // low bits mirror the read request sent to forwarding
        t.raw_instr = {raw_hi[31:18], t.ra1, t.ra2, t.cp0ra,
                       t.hi_read, t.lo_read, t.cp0_read};
        return t;
    endfunction

    // a branch only ever sits in lane 0 with its slot beside it
    task automatic offer_new();
        logic [31:0] r;
        r   = next_rand();
        dec = '0;
        if (r[1:0] == 2'd1) begin
            dec[0]  = make_inst(next_pc, 1'b0);
            next_pc = next_pc + 32'd4;
        end else if (r[1:0] != 2'd0) begin
            dec[0]  = make_inst(next_pc, 1'b1);
            dec[1]  = make_inst(next_pc + 32'd4, 1'b0);
            next_pc = next_pc + 32'd8;
        end
    endtask

    task automatic set_operands(logic [6:0] ready_lvl);
        logic [31:0] r;
        for (int i = 0; i < 2; i++) begin
            r               = next_rand();
            opnd1[i].ready  = r[6:0] <= ready_lvl;
            opnd1[i].bypass = r[7];
            opnd2[i].ready  = r[14:8] <= ready_lvl;
            opnd2[i].bypass = r[15];
            opnd1[i].data   = next_rand();
            opnd2[i].data   = next_rand();
            rf_rd1[i]       = next_rand();
            rf_rd2[i]       = next_rand();
        end
    endtask

    task automatic run_phase(string name, int cycles, logic [6:0] stall_lvl,
                             logic [6:0] flush_lvl, logic [6:0] ready_lvl);
        logic [31:0] r;
        int          base;
        int          guard;
        logic        bad;
        base = dut_i.chk_i.fail_cnt;
        bad  = 1'b0;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (flush) begin
                // redirect after a flush since the offered pair was dropped
                next_pc = next_pc + 32'h100;
                offer_new();
            end else if (taken) begin
                offer_new();
            end
            r           = next_rand();
            stall_issue = r[6:0] < stall_lvl;
            flush       = r[13:7] < flush_lvl;
            set_operands(ready_lvl);
            taken = !full;
        end
        // drain with every operand ready
        guard = 0;
        while (guard < 200 && (flush || dec[0].valid || dut_i.count != '0)) begin
            @(negedge clk);
            if (flush || taken) begin
                dec = '0;
            end
            flush       = 1'b0;
            stall_issue = 1'b0;
            set_operands(7'd127);
            taken = !full;
            guard++;
        end
        if (guard >= 200) begin
            $display("%s: queue still holds entries after 200 drain cycles", name);
            bad = 1'b1;
        end
        if (dut_i.chk_i.fail_cnt != base) begin
            bad = 1'b1;
        end
        tests_run++;
        if (bad) begin
            tests_failed++;
        end
        $display("test %s %s", name, bad ? "FAIL" : "PASS");
    endtask

    initial begin
        rng          = 32'd78468;
        next_pc      = 32'h0000_1000;
        taken        = 1'b1;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        dec          = '0;
        rf_rd1       = '0;
        rf_rd2       = '0;
        opnd1        = '0;
        opnd2        = '0;
        flush        = 1'b0;
        stall_issue  = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        run_phase("program_order", 200, 7'd0, 7'd0, 7'd100);
        run_phase("pair_conflicts", 200, 7'd0, 7'd0, 7'd127);
        run_phase("delay_slot", 200, 7'd10, 7'd0, 7'd90);
        run_phase("operand_select", 200, 7'd10, 7'd0, 7'd110);
        run_phase("stall_flush_full", 300, 7'd100, 7'd4, 7'd80);

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/issue_pkg.sv
hdl/issue_ptrs.sv
hdl/issue_buffer.sv
hdl/pair_check.sv
hdl/operand_sel.sv
hdl/issue_stage.sv
sim/issue_stage_assert.sv
sim/issue_stage_tb.sv
